//--- design/vdp_vram_pkg.sv
package vdp_vram_pkg;

	//##########################################################################
	// Sizes.
	//##########################################################################

	// Array address width: row byte on top of column byte.
	localparam int RAM_AW = 16;

	// Default width of the line fetch byte count.
	localparam int LINE_CNT_W = 8;

	//##########################################################################
	// Basic types.
	//##########################################################################

	typedef logic [RAM_AW-1:0] vram_addr_t;
	typedef logic [7:0] vram_data_t;

	// Cycle kinds run by the sequencer.
	typedef enum logic [1:0]
	{
		OP_READ  = 2'd0,
		OP_WRITE = 2'd1,
		OP_XFER  = 2'd2
	} vram_op_e;

	// One random or transfer request.
	typedef struct packed
	{
		vram_op_e op;
		vram_addr_t addr;
		vram_data_t wdata;
	} vram_req_t;

	// Read response, echoes the address.
	typedef struct packed
	{
		vram_addr_t addr;
		vram_data_t data;
	} vram_rsp_t;

	// Line fetch: start address and byte count.
	typedef struct packed
	{
		vram_addr_t addr;
		logic [LINE_CNT_W-1:0] count;
	} line_req_t;

endpackage

//--- design/vram_dual_ram.sv
`timescale 1ns/100ps

module vram_dual_ram
	import vdp_vram_pkg::*;
	#(
	parameter int AW = RAM_AW
	)
	(
	input  logic MCLK,
	input  logic [AW-1:0] i_addr0,
	input  logic [AW-1:0] i_addr1,
	input  logic i_we1,
	input  vram_data_t i_data1,
	output vram_data_t o_q0,
	output vram_data_t o_q1
	);

	// Storage array, one byte per location.
	vram_data_t mem [0:(1<<AW)-1];

	//##########################################################################
	// Port 0, read only.
	//##########################################################################

	// Registered read for the serial side.
	always_ff @(posedge MCLK)
	begin
		o_q0 <= mem[i_addr0];
	end

	//##########################################################################
	// Port 1, read and write.
	//##########################################################################

	// Read returns the old contents on a write clock.
	always_ff @(posedge MCLK)
	begin
		if (i_we1)
		begin
			mem[i_addr1] <= i_data1;
		end
		o_q1 <= mem[i_addr1];
	end

endmodule

//--- design/vram.sv
`timescale 1ns/100ps

module vram
	import vdp_vram_pkg::*;
	(
	input  logic MCLK,
	input  logic i_ras,
	input  logic i_cas,
	input  logic i_we,
	input  logic i_oe,
	input  logic i_sc,
	input  logic i_se,
	input  vram_data_t i_ad,
	input  vram_data_t i_rd,
	output vram_data_t o_rd,
	output logic o_rd_d,
	output vram_data_t o_sd,
	output logic o_sd_d
	);

	// Latched row and column.
	vram_addr_t addr;
	// Transfer flag set by OE low at RAS fall.
	logic dt;
	// Serial pointer and its output register.
	vram_addr_t ser_ptr;
	vram_data_t ser_q;
	vram_data_t sd_reg;
	// Random read data valid.
	logic rd_valid;

	// Delayed strobe copies.
	logic ras_q;
	logic oe_q;
	logic sc_q;
	logic cas_act_q;

	logic cas_act;
	logic wr;
	logic rd;
	logic ras_fall;
	logic cas_fall;
	logic oe_rise;
	logic sc_rise;

	//##########################################################################
	// Cycle decode.
	//##########################################################################

	// Column strobe only counts inside a row cycle.
	assign cas_act = ~i_ras & ~i_cas;
	assign wr = cas_act & ~i_we;
	// No random read during a transfer cycle.
	assign rd = cas_act & ~i_oe & ~dt;

	// Edges against last clock's pin state.
	assign ras_fall = ras_q & ~i_ras;
	assign cas_fall = ~cas_act_q & cas_act;
	assign oe_rise = ~oe_q & i_oe;
	assign sc_rise = ~sc_q & i_sc;

	vram_dual_ram #(
		.AW(RAM_AW)
	) u_array (
		.MCLK    (MCLK),
		.i_addr0 (ser_ptr),
		.i_addr1 (addr),
		.i_we1   (wr),
		.i_data1 (i_rd),
		.o_q0    (ser_q),
		.o_q1    (o_rd)
	);

	//##########################################################################
	// Address latch, transfer and serial pointer.
	//##########################################################################

	always_ff @(posedge MCLK)
	begin
		// Transfer ends on OE release and loads the full pointer.
		if (dt & oe_rise)
		begin
			ser_ptr <= addr;
		end
		else if (sc_rise)
		begin
			// Only the column moves, so it wraps within the row.
			ser_ptr[7:0] <= ser_ptr[7:0] + 8'd1;
			sd_reg <= ser_q;
		end

		if (ras_fall)
		begin
			dt <= ~i_oe;
			addr[15:8] <= i_ad;
		end
		if (cas_fall)
		begin
			addr[7:0] <= i_ad;
		end

		// Data valid one clock after read condition.
		if (rd)
		begin
			rd_valid <= 1'b1;
		end
		else if (i_cas | i_oe)
		begin
			rd_valid <= 1'b0;
		end

		ras_q <= i_ras;
		oe_q <= i_oe;
		sc_q <= i_sc;
		cas_act_q <= cas_act;
	end

	// Drive flags are low while driving.
	assign o_rd_d = ~rd_valid;
	assign o_sd_d = i_se;
	assign o_sd = sd_reg;

	// Controller must never enable write and output together while CAS stays low.
	a_we_oe_excl: assert property (@(posedge MCLK)
		(cas_act && cas_act_q) |-> (i_we | i_oe))
		else $error("vram: WE and OE both low during CAS");

endmodule

//--- design/vram_cycle_sequencer.sv
`timescale 1ns/100ps

module vram_cycle_sequencer
	import vdp_vram_pkg::*;
	(
	input  logic MCLK,
	input  logic i_rst,
	input  vram_req_t i_req,
	input  logic i_req_valid,
	output logic o_req_ready,
	output vram_rsp_t o_rsp,
	output logic o_rsp_valid,
	input  logic i_rsp_ready,
	input  vram_req_t i_xfer,
	input  logic i_xfer_valid,
	output logic o_xfer_done,
	output logic o_ras,
	output logic o_cas,
	output logic o_we,
	output logic o_oe,
	output vram_data_t o_ad,
	output vram_data_t o_wd,
	input  vram_data_t i_rd,
	input  logic i_rd_d
	);

	// Longest wait for chip read data.
	localparam int RD_WAIT = 4;

	typedef enum logic [2:0]
	{
		S_IDLE,
		S_ROW,
		S_COL,
		S_STRB,
		S_PRE
	} seq_state_e;

	seq_state_e state;
	// Request being played out.
	vram_req_t cur;
	logic [$clog2(RD_WAIT)-1:0] wait_cnt;

	logic take_xfer;
	logic take_req;
	logic rd_timeout;
	logic rd_done;

	//##########################################################################
	// Arbitration.
	//##########################################################################

	// Transfer wins; blocked in the done cycle so it is not taken twice.
	assign take_xfer = (state == S_IDLE) && i_xfer_valid && !o_xfer_done;
	// No random request while a response waits.
	assign o_req_ready = (state == S_IDLE) && !o_rsp_valid && !take_xfer;
	assign take_req = o_req_ready && i_req_valid;

	// Read wait ends on chip data valid or on the bound.
	assign rd_timeout = (state == S_STRB) && (cur.op == OP_READ) && i_rd_d &&
		(wait_cnt == $bits(wait_cnt)'(RD_WAIT-1));
	assign rd_done = (state == S_STRB) && (cur.op == OP_READ) && (!i_rd_d || rd_timeout);

	//##########################################################################
	// Strobe FSM.
	//##########################################################################

	always_ff @(posedge MCLK)
	begin
		if (i_rst)
		begin
			state <= S_IDLE;
			o_ras <= 1'b1;
			o_cas <= 1'b1;
			o_we <= 1'b1;
			o_oe <= 1'b1;
			o_rsp_valid <= 1'b0;
			o_xfer_done <= 1'b0;
			wait_cnt <= '0;
		end
		else
		begin
			o_xfer_done <= 1'b0;
			if (o_rsp_valid && i_rsp_ready)
			begin
				o_rsp_valid <= 1'b0;
			end

			case (state)
			S_IDLE:
			begin
				// Row phase; OE low at RAS fall marks a transfer.
				if (take_xfer)
				begin
					o_ras <= 1'b0;
					o_oe <= 1'b0;
					state <= S_ROW;
				end
				else if (take_req)
				begin
					o_ras <= 1'b0;
					state <= S_ROW;
				end
			end
			S_ROW:
			begin
				// Column phase.
				o_cas <= 1'b0;
				state <= S_COL;
			end
			S_COL:
			begin
				// Strobe phase, or OE release for a transfer.
				case (cur.op)
				OP_WRITE: o_we <= 1'b0;
				OP_READ: o_oe <= 1'b0;
				default: o_oe <= 1'b1;
				endcase
				wait_cnt <= '0;
				state <= S_STRB;
			end
			S_STRB:
			begin
				if ((cur.op == OP_READ) && !rd_done)
				begin
					wait_cnt <= wait_cnt + 1'b1;
				end
				else
				begin
					if (cur.op == OP_READ)
					begin
						o_rsp_valid <= 1'b1;
					end
					o_ras <= 1'b1;
					o_cas <= 1'b1;
					o_we <= 1'b1;
					o_oe <= 1'b1;
					state <= S_PRE;
				end
			end
			S_PRE:
			begin
				// Precharge, then report the transfer.
				if (cur.op == OP_XFER)
				begin
					o_xfer_done <= 1'b1;
				end
				state <= S_IDLE;
			end
			default:
			begin
				state <= S_IDLE;
			end
			endcase
		end
	end

	//##########################################################################
	// Payload: address mux, write data, read capture.
	//##########################################################################

	always_ff @(posedge MCLK)
	begin
		if (take_xfer)
		begin
			cur <= i_xfer;
			o_ad <= i_xfer.addr[15:8];
		end
		else if (take_req)
		begin
			cur <= i_req;
			o_ad <= i_req.addr[15:8];
			o_wd <= i_req.wdata;
		end
		// Column goes out with CAS.
		if (state == S_ROW)
		begin
			o_ad <= cur.addr[7:0];
		end
		if (rd_done)
		begin
			o_rsp.addr <= cur.addr;
			o_rsp.data <= i_rd;
		end
	end

	// Stalled client request must hold.
	a_req_stable: assert property (@(posedge MCLK) disable iff (i_rst)
		(i_req_valid && !o_req_ready) |=> (i_req_valid && $stable(i_req)))
		else $error("sequencer: request changed while stalled");

	// Chip must answer reads within the bound.
	a_rd_wait: assert property (@(posedge MCLK) disable iff (i_rst) !rd_timeout)
		else $error("sequencer: read data wait expired");

endmodule

//--- design/vram_serial_reader.sv
`timescale 1ns/100ps

module vram_serial_reader
	import vdp_vram_pkg::*;
	#(
	parameter int LINE_CNT_W = vdp_vram_pkg::LINE_CNT_W
	)
	(
	input  logic MCLK,
	input  logic i_rst,
	input  line_req_t i_line,
	input  logic i_line_valid,
	output logic o_line_ready,
	output vram_req_t o_xfer,
	output logic o_xfer_valid,
	input  logic i_xfer_done,
	output logic o_sc,
	output logic o_se,
	input  vram_data_t i_sd,
	input  logic i_sd_d,
	output vram_data_t o_pix,
	output logic o_pix_valid,
	input  logic i_pix_ready
	);

	typedef enum logic [1:0]
	{
		R_IDLE,
		R_XFER,
		R_SETTLE,
		R_RUN
	} rd_state_e;

	rd_state_e state;
	// Bytes still to clock out and still to hand over.
	logic [LINE_CNT_W-1:0] req_left;
	logic [LINE_CNT_W-1:0] out_left;
	logic settle_cnt;
	// SC pulse done but chip byte not taken yet.
	logic pend;

	logic held;
	logic sd_take;
	logic sc_fire;
	logic pix_acc;

	assign o_line_ready = (state == R_IDLE);

	// Byte stuck under back-pressure.
	assign held = o_pix_valid && !i_pix_ready;
	assign pix_acc = o_pix_valid && i_pix_ready;
	// Take chip byte once the slot frees.
	assign sd_take = pend && !i_sd_d && !held;
	// Next pulse only when the previous byte leaves this edge.
	assign sc_fire = (state == R_RUN) && (req_left != '0) && !o_sc && !held &&
		(!pend || sd_take);

	always_ff @(posedge MCLK)
	begin
		if (i_rst)
		begin
			state <= R_IDLE;
			o_xfer_valid <= 1'b0;
			o_sc <= 1'b0;
			o_se <= 1'b1;
			o_pix_valid <= 1'b0;
			pend <= 1'b0;
			settle_cnt <= 1'b0;
			req_left <= '0;
			out_left <= '0;
		end
		else
		begin
			// One clock high and at least one low.
			o_sc <= sc_fire;
			if (sc_fire)
			begin
				req_left <= req_left - 1'b1;
			end
			if (o_sc)
			begin
				pend <= 1'b1;
			end
			else if (sd_take)
			begin
				pend <= 1'b0;
			end
			if (sd_take)
			begin
				o_pix_valid <= 1'b1;
			end
			else if (pix_acc)
			begin
				o_pix_valid <= 1'b0;
			end
			if (pix_acc)
			begin
				out_left <= out_left - 1'b1;
			end

			case (state)
			R_IDLE:
			begin
				if (i_line_valid)
				begin
					o_xfer_valid <= 1'b1;
					o_se <= 1'b0;
					req_left <= LINE_CNT_W'(i_line.count);
					out_left <= LINE_CNT_W'(i_line.count);
					state <= R_XFER;
				end
			end
			R_XFER:
			begin
				if (i_xfer_done)
				begin
					o_xfer_valid <= 1'b0;
					settle_cnt <= 1'b0;
					state <= R_SETTLE;
				end
			end
			R_SETTLE:
			begin
				// Two clocks for the serial port read.
				settle_cnt <= ~settle_cnt;
				if (settle_cnt)
				begin
					state <= R_RUN;
				end
			end
			default:
			begin
				// Line done once every byte is taken.
				if (out_left == '0)
				begin
					o_se <= 1'b1;
					state <= R_IDLE;
				end
			end
			endcase
		end
	end

	// Payload registers.
	always_ff @(posedge MCLK)
	begin
		if ((state == R_IDLE) && i_line_valid)
		begin
			o_xfer.op <= OP_XFER;
			o_xfer.addr <= i_line.addr;
			o_xfer.wdata <= '0;
		end
		if (sd_take)
		begin
			o_pix <= i_sd;
		end
	end

	// An SC pulse never runs while the previous chip byte still waits.
	a_no_sc_held: assert property (@(posedge MCLK) disable iff (i_rst)
		o_sc |-> !pend)
		else $error("reader: SC pulsed with a chip byte still pending");

endmodule

//--- design/vdp_vram_subsys.sv
`timescale 1ns/100ps

module vdp_vram_subsys
	import vdp_vram_pkg::*;
	#(
	parameter int LINE_CNT_W = vdp_vram_pkg::LINE_CNT_W
	)
	(
	input  logic MCLK,
	input  logic i_rst,
	// Random port.
	input  vram_req_t i_req,
	input  logic i_req_valid,
	output logic o_req_ready,
	output vram_rsp_t o_rsp,
	output logic o_rsp_valid,
	input  logic i_rsp_ready,
	// Line port.
	input  line_req_t i_line,
	input  logic i_line_valid,
	output logic o_line_ready,
	output vram_data_t o_pix,
	output logic o_pix_valid,
	input  logic i_pix_ready
	);

	// Chip pins, strobes active low.
	logic ras;
	logic cas;
	logic we;
	logic oe;
	logic sc;
	logic se;
	vram_data_t ad;
	vram_data_t rd_i;
	vram_data_t rd_o;
	logic rd_d;
	vram_data_t sd_o;
	logic sd_d;

	// Reader to sequencer transfer path.
	vram_req_t xfer_req;
	logic xfer_valid;
	logic xfer_done;

	vram_cycle_sequencer u_seq (
		.MCLK         (MCLK),
		.i_rst        (i_rst),
		.i_req        (i_req),
		.i_req_valid  (i_req_valid),
		.o_req_ready  (o_req_ready),
		.o_rsp        (o_rsp),
		.o_rsp_valid  (o_rsp_valid),
		.i_rsp_ready  (i_rsp_ready),
		.i_xfer       (xfer_req),
		.i_xfer_valid (xfer_valid),
		.o_xfer_done  (xfer_done),
		.o_ras        (ras),
		.o_cas        (cas),
		.o_we         (we),
		.o_oe         (oe),
		.o_ad         (ad),
		.o_wd         (rd_i),
		.i_rd         (rd_o),
		.i_rd_d       (rd_d)
	);

	vram_serial_reader #(
		.LINE_CNT_W(LINE_CNT_W)
	) u_reader (
		.MCLK         (MCLK),
		.i_rst        (i_rst),
		.i_line       (i_line),
		.i_line_valid (i_line_valid),
		.o_line_ready (o_line_ready),
		.o_xfer       (xfer_req),
		.o_xfer_valid (xfer_valid),
		.i_xfer_done  (xfer_done),
		.o_sc         (sc),
		.o_se         (se),
		.i_sd         (sd_o),
		.i_sd_d       (sd_d),
		.o_pix        (o_pix),
		.o_pix_valid  (o_pix_valid),
		.i_pix_ready  (i_pix_ready)
	);

	vram u_vram (
		.MCLK   (MCLK),
		.i_ras  (ras),
		.i_cas  (cas),
		.i_we   (we),
		.i_oe   (oe),
		.i_sc   (sc),
		.i_se   (se),
		.i_ad   (ad),
		.i_rd   (rd_i),
		.o_rd   (rd_o),
		.o_rd_d (rd_d),
		.o_sd   (sd_o),
		.o_sd_d (sd_d)
	);

endmodule

//--- verification/vdp_vram_subsys_checks.svh
//############################################################################
// Failure handling.
//############################################################################

// Checks that went wrong.
int error_count;

// Stop the run with a reason.
task automatic fail_run(input string reason);
	$display("%s", reason);
	$display("Result: FAILED");
	$fatal(1, "simulation stopped");
endtask

//############################################################################
// Compare tasks.
//############################################################################

// Read response, address echo and data.
task automatic compare_rsp(input vram_rsp_t actual, input vram_rsp_t expected);
	if (actual !== expected)
	begin
		error_count++;
		$display("** Error at %0t: o_rsp addr/data = %h/%h, expected %h/%h",
			$time, actual.addr, actual.data, expected.addr, expected.data);
		fail_run("read response does not match the reference memory");
	end
endtask

// One line fetch byte.
task automatic compare_pix(input vram_data_t actual, input vram_data_t expected,
	input int index);
	if (actual !== expected)
	begin
		error_count++;
		$display("** Error at %0t: o_pix[%0d] = %h, expected %h",
			$time, index, actual, expected);
		fail_run("line fetch byte does not match the reference memory");
	end
endtask

// Single handshake flag.
task automatic compare_flag(input logic actual, input logic expected, input string name);
	if (actual !== expected)
	begin
		error_count++;
		$display("** Error at %0t: %s = %b, expected %b", $time, name, actual, expected);
		fail_run("handshake flag has the wrong value");
	end
endtask

//--- verification/vdp_vram_subsys_tb.sv
`timescale 1ns/100ps

module vdp_vram_subsys_tb
	import vdp_vram_pkg::*;
	();

	// Wait bounds in cycles.
	localparam int TIMEOUT = 300;
	localparam int RD_LATENCY = 8;

	logic MCLK;
	logic i_rst;
	vram_req_t i_req;
	logic i_req_valid;
	logic o_req_ready;
	vram_rsp_t o_rsp;
	logic o_rsp_valid;
	logic i_rsp_ready;
	line_req_t i_line;
	logic i_line_valid;
	logic o_line_ready;
	vram_data_t o_pix;
	logic o_pix_valid;
	logic i_pix_ready;

	// Mirror of every byte written.
	vram_data_t ref_mem [0:65535];

	`include "vdp_vram_subsys_checks.svh"

	vdp_vram_subsys #(
		.LINE_CNT_W(LINE_CNT_W)
	) i_dut (
		.MCLK         (MCLK),
		.i_rst        (i_rst),
		.i_req        (i_req),
		.i_req_valid  (i_req_valid),
		.o_req_ready  (o_req_ready),
		.o_rsp        (o_rsp),
		.o_rsp_valid  (o_rsp_valid),
		.i_rsp_ready  (i_rsp_ready),
		.i_line       (i_line),
		.i_line_valid (i_line_valid),
		.o_line_ready (o_line_ready),
		.o_pix        (o_pix),
		.o_pix_valid  (o_pix_valid),
		.i_pix_ready  (i_pix_ready)
	);

	// 4 ns clock.
	initial
	begin
		MCLK = 1'b0;
		forever
		begin
			#2 MCLK = ~MCLK;
		end
	end

	//########################################################################
	// Bus helpers.
	//########################################################################

	// Hold the request until the sequencer takes it.
	task automatic send_req(input vram_req_t req);
		int waited;
		waited = 0;
		@(negedge MCLK);
		i_req = req;
		i_req_valid = 1'b1;
		while (!o_req_ready)
		begin
			@(negedge MCLK);
			waited++;
			if (waited > TIMEOUT)
			begin
				fail_run("random request was never accepted");
			end
		end
		@(negedge MCLK);
		i_req_valid = 1'b0;
	endtask

	task automatic write_byte(input vram_addr_t addr, input vram_data_t data);
		vram_req_t req;
		req.op = OP_WRITE;
		req.addr = addr;
		req.wdata = data;
		send_req(req);
		ref_mem[addr] = data;
	endtask

	// Read and check latency, then the response under optional back-pressure.
	task automatic read_check(input vram_addr_t addr, input bit use_bp);
		vram_req_t req;
		vram_rsp_t exp;
		int cycles;
		bit seen;
		bit got;
		req.op = OP_READ;
		req.addr = addr;
		req.wdata = '0;
		exp.addr = addr;
		exp.data = ref_mem[addr];
		send_req(req);
		// Edges counted after the acceptance edge.
		cycles = 0;
		seen = 1'b0;
		got = 1'b0;
		while (!got)
		begin
			if (o_rsp_valid && !seen)
			begin
				seen = 1'b1;
				if (cycles > RD_LATENCY)
				begin
					fail_run("read response arrived later than 8 cycles");
				end
			end
			i_rsp_ready = use_bp ? (($urandom % 4) != 0) : 1'b1;
			if (o_rsp_valid && i_rsp_ready)
			begin
				compare_rsp(o_rsp, exp);
				got = 1'b1;
			end
			@(negedge MCLK);
			cycles++;
			if (cycles > TIMEOUT)
			begin
				fail_run("read response never arrived");
			end
		end
		i_rsp_ready = 1'b0;
	endtask

	// Known bytes at every column a fetch will touch.
	task automatic fill_line(input vram_addr_t start, input int count);
		vram_addr_t a;
		int k;
		for (k = 0; k < count; k++)
		begin
			a = {start[15:8], start[7:0] + 8'(k)};
			write_byte(a, vram_data_t'($urandom));
		end
	endtask

	// Byte k comes from the start row with the column wrapping at 256.
	task automatic fetch_line(input vram_addr_t start, input int count, input bit use_bp);
		line_req_t line;
		vram_addr_t a;
		int got;
		int waited;
		line.addr = start;
		line.count = count[LINE_CNT_W-1:0];
		waited = 0;
		@(negedge MCLK);
		i_line = line;
		i_line_valid = 1'b1;
		while (!o_line_ready)
		begin
			@(negedge MCLK);
			waited++;
			if (waited > TIMEOUT)
			begin
				fail_run("line request was never accepted");
			end
		end
		@(negedge MCLK);
		i_line_valid = 1'b0;
		got = 0;
		waited = 0;
		while (got < count)
		begin
			i_pix_ready = use_bp ? (($urandom % 3) != 0) : 1'b1;
			if (o_pix_valid && i_pix_ready)
			begin
				a = {start[15:8], start[7:0] + 8'(got)};
				compare_pix(o_pix, ref_mem[a], got);
				got++;
				waited = 0;
			end
			@(negedge MCLK);
			waited++;
			if (waited > TIMEOUT)
			begin
				fail_run("line fetch stopped before its last byte");
			end
		end
		i_pix_ready = 1'b0;
		// Reader returns to idle with no extra byte.
		waited = 0;
		while (!o_line_ready)
		begin
			if (o_pix_valid)
			begin
				fail_run("line fetch produced more bytes than requested");
			end
			@(negedge MCLK);
			waited++;
			if (waited > TIMEOUT)
			begin
				fail_run("reader did not return to idle after the fetch");
			end
		end
	endtask

	//########################################################################
	// Directed tests.
	//########################################################################

	task automatic check_reset();
		$display("Test: state after reset");
		compare_flag(o_req_ready, 1'b1, "o_req_ready");
		compare_flag(o_line_ready, 1'b1, "o_line_ready");
		compare_flag(o_rsp_valid, 1'b0, "o_rsp_valid");
		compare_flag(o_pix_valid, 1'b0, "o_pix_valid");
	endtask

	task automatic write_then_read();
		$display("Test: write then read back");
		write_byte(16'h1234, 8'h5a);
		read_check(16'h1234, 1'b0);
	endtask

	task automatic random_write_read();
		vram_addr_t addrs[$];
		vram_addr_t a;
		int i;
		$display("Test: random writes and reads with back-pressure");
		for (i = 0; i < 40; i++)
		begin
			a = vram_addr_t'($urandom);
			write_byte(a, vram_data_t'($urandom));
			addrs.push_back(a);
		end
		for (i = 0; i < 40; i++)
		begin
			read_check(addrs[$urandom % addrs.size()], 1'b1);
		end
	endtask

	task automatic plain_and_wrapped_fetch();
		$display("Test: line fetches, plain and wrapping");
		fill_line(16'h2010, 32);
		fetch_line(16'h2010, 32, 1'b0);
		// Crosses column ff back to 00.
		fill_line(16'h37f0, 40);
		fetch_line(16'h37f0, 40, 1'b0);
	endtask

	task automatic fetch_under_backpressure();
		$display("Test: line fetch with pixel back-pressure");
		fill_line(16'h5ae0, 64);
		fetch_line(16'h5ae0, 64, 1'b1);
	endtask

	task automatic read_during_fetch();
		$display("Test: random read during a line fetch");
		fill_line(16'h6a00, 48);
		write_byte(16'h7c33, vram_data_t'($urandom));
		fork
			begin
				fetch_line(16'h6a00, 48, 1'b1);
			end
			begin
				repeat (12) @(negedge MCLK);
				read_check(16'h7c33, 1'b0);
			end
		join
	endtask

	//########################################################################
	// Main sequence.
	//########################################################################

	initial
	begin
		void'($urandom(32'h34ac));
		error_count = 0;
		i_rst = 1'b1;
		i_req = '0;
		i_req_valid = 1'b0;
		i_rsp_ready = 1'b0;
		i_line = '0;
		i_line_valid = 1'b0;
		i_pix_ready = 1'b0;
		repeat (5) @(posedge MCLK);
		@(negedge MCLK);
		i_rst = 1'b0;
		@(negedge MCLK);
		check_reset();
		write_then_read();
		random_write_read();
		plain_and_wrapped_fetch();
		fetch_under_backpressure();
		read_during_fetch();
		if (error_count == 0)
		begin
			$display("Result: PASSED");
			$finish;
		end
		else
		begin
			fail_run("one or more checks failed");
		end
	end

endmodule

//--- vdp_vram_subsys.f
+incdir+verification
design/vdp_vram_pkg.sv
design/vram_dual_ram.sv
design/vram.sv
design/vram_cycle_sequencer.sv
design/vram_serial_reader.sv
design/vdp_vram_subsys.sv
verification/vdp_vram_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the VRAM subsystem testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
SIM_BIN=obj_dir/vdp_vram_subsys_sim

verilator --binary --timing --assert -sv -Wno-fatal \
	-f vdp_vram_subsys.f \
	--top-module vdp_vram_subsys_tb \
	-Mdir obj_dir -o vdp_vram_subsys_sim > "$BUILD_LOG" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed with status $build_status"
	exit 1
fi

./"$SIM_BIN" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^Result: PASSED$" "$SIM_LOG"; then
	exit 0
else
	echo "Pass message not found in $SIM_LOG"
	exit 1
fi
